// ==== emesh_pkg.sv ====
package emesh_pkg;

   // ##############################
   // Packet geometry
   // ##############################
   localparam int PW = 104;           // Full mesh packet, one word
   localparam int AW = 32;            // Address and data width

   // Field offsets, LSB first
   localparam int WRITE_BIT    = 0;
   localparam int DATAMODE_LSB = 1;
   localparam int DM_W         = 2;   // Data mode width
   localparam int CTRLMODE_LSB = 3;
   localparam int CM_W         = 5;   // Control mode width
   localparam int DSTADDR_LSB  = 8;
   localparam int DATA_LSB     = 40;
   localparam int SRCADDR_LSB  = 72;

   // ##############################
   // Data mode encoding
   // ##############################
   typedef enum logic [DM_W-1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,               // Only mode the GPIO block really serves
      DM_DOUBLE = 2'd3
   } datamode_e;

endpackage

// ==== gpio_pkg.sv ====
package gpio_pkg;

   localparam int GW = 32;            // GPIO pins

   // Response flow control
   localparam int RESP_CREDITS = 2;   // Credits held after reset
   localparam int CREDIT_W     = 2;   // Counter width

   // Register select from dstaddr[4:2]
   localparam int REG_ADDR_LSB = 2;
   localparam int REG_ADDR_W   = 3;

   typedef enum logic [REG_ADDR_W-1:0] {
      REG_DIR    = 3'd0,              // Output enables
      REG_IN     = 3'd1,              // Synced pin values, read only
      REG_OUT    = 3'd2,
      REG_OUTCLR = 3'd3,
      REG_OUTSET = 3'd4,
      REG_OUTXOR = 3'd5,
      REG_IMASK  = 3'd6,              // 1 masks the interrupt
      REG_ILAT   = 3'd7               // Edge latch, write 1 to clear
   } gpio_reg_e;

   typedef enum logic {ST_IDLE, ST_RESP} ctrl_state_e;

endpackage

// ==== gpio_input_sync.sv ====
module gpio_input_sync
   import gpio_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic [GW-1:0] pins,
   output logic [GW-1:0] pins_sync,
   output logic [GW-1:0] rise
);

   logic [GW-1:0] meta_q;    // First stage, may go metastable
   logic [GW-1:0] sync_q;    // Second stage, safe to use
   logic [GW-1:0] prev_q;    // Last synced value

   always_ff @(posedge clk) begin
      if (reset) begin
         meta_q <= '0;
         sync_q <= '0;
         prev_q <= '0;
      end else begin
         meta_q <= pins;
         sync_q <= meta_q;
         prev_q <= sync_q;
      end
   end

   assign pins_sync = sync_q;

   // Low to high on the synced value
   assign rise = sync_q & ~prev_q;

endmodule

// ==== gpio_regs.sv ====
module gpio_regs
   import gpio_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          reg_wr,
   input  gpio_reg_e     reg_sel,
   input  logic [GW-1:0] wr_data,
   input  logic [GW-1:0] pins_sync,
   input  logic [GW-1:0] rise,
   output logic [GW-1:0] rd_data,
   output logic [GW-1:0] gpio_out,
   output logic [GW-1:0] gpio_en,
   output logic          gpio_irq
);

   logic [GW-1:0] dir_q;
   logic [GW-1:0] out_q;
   logic [GW-1:0] imask_q;
   logic [GW-1:0] ilat_q;
   logic [GW-1:0] ilat_clr;

   // Write 1 to clear the edge latch
   assign ilat_clr = (reg_wr && reg_sel == REG_ILAT) ? wr_data : '0;

   // ##############################
   // Register writes
   // ##############################
   always_ff @(posedge clk) begin
      if (reset) begin
         dir_q   <= '0;
         out_q   <= '0;
         imask_q <= '0;
         ilat_q  <= '0;
      end else begin
         ilat_q <= (ilat_q & ~ilat_clr) | rise;   // New edge beats clear
         if (reg_wr) begin
            case (reg_sel)
               REG_DIR:    dir_q   <= wr_data;
               REG_OUT:    out_q   <= wr_data;
               REG_OUTCLR: out_q   <= out_q & ~wr_data;
               REG_OUTSET: out_q   <= out_q | wr_data;
               REG_OUTXOR: out_q   <= out_q ^ wr_data;
               REG_IMASK:  imask_q <= wr_data;
               default: ;                         // REG_IN read only, ILAT above
            endcase
         end
      end
   end

   // ##############################
   // Read mux
   // ##############################
   always_comb begin
      case (reg_sel)
         REG_DIR:   rd_data = dir_q;
         REG_IN:    rd_data = pins_sync;
         REG_IMASK: rd_data = imask_q;
         REG_ILAT:  rd_data = ilat_q;
         default:   rd_data = out_q;              // OUT and its set/clr/xor aliases
      endcase
   end

   assign gpio_out = out_q;
   assign gpio_en  = dir_q;

   // Any unmasked latched edge
   assign gpio_irq = |(ilat_q & ~imask_q);

endmodule

// ==== credit_counter.sv ====
module credit_counter
   import gpio_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic credit_in,
   input  logic consume,
   output logic has_credit
);

   logic [CREDIT_W-1:0] count_q;   // Credits the block may still spend

   always_ff @(posedge clk) begin
      if (reset) begin
         count_q <= CREDIT_W'(RESP_CREDITS);
      end else begin
         case ({credit_in, consume})
            2'b10: begin
               // Extra returns above the start value are dropped
               if (count_q != CREDIT_W'(RESP_CREDITS))
                  count_q <= count_q + 1'b1;
            end
            2'b01: begin
               if (count_q != '0)
                  count_q <= count_q - 1'b1;
            end
            default: ;                 // Both or neither, no change
         endcase
      end
   end

   assign has_credit = (count_q != '0);

endmodule

// ==== gpio_ctrl_fsm.sv ====
module gpio_ctrl_fsm
   import emesh_pkg::*, gpio_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          access_in,
   input  logic [PW-1:0] packet_in,
   input  logic          has_credit,
   output logic          wait_out,
   output logic          reg_wr,
   output gpio_reg_e     reg_sel,
   output logic [GW-1:0] wr_data,
   output logic          resp_load,
   output logic          resp_send,
   output logic [AW-1:0] resp_dst
);

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   logic        accept;
   logic        is_write;

   // ##############################
   // Request decode
   // ##############################
   assign accept   = access_in && (state_q == ST_IDLE);
   assign is_write = packet_in[WRITE_BIT];

   // Data and ctrl mode fields ignored, every access is a word
   assign reg_sel  = gpio_reg_e'(packet_in[DSTADDR_LSB + REG_ADDR_LSB +: REG_ADDR_W]);
   assign wr_data  = packet_in[DATA_LSB +: GW];
   assign resp_dst = packet_in[SRCADDR_LSB +: AW];   // Reply goes back to sender

   assign reg_wr    = accept && is_write;    // Register updates on this edge
   assign resp_load = accept && !is_write;   // Packer grabs the read value now

   // Fire as soon as a credit is there
   assign resp_send = (state_q == ST_RESP) && has_credit;

   assign wait_out = (state_q == ST_RESP);   // One read outstanding at most

   // ##############################
   // State register
   // ##############################
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: if (resp_load)  state_d = ST_RESP;
         ST_RESP: if (has_credit) state_d = ST_IDLE;
         default:                 state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state_q <= ST_IDLE;
      else
         state_q <= state_d;
   end

endmodule

// ==== resp_packer.sv ====
module resp_packer
   import emesh_pkg::*, gpio_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          resp_load,
   input  logic          resp_send,
   input  logic [GW-1:0] rd_data,
   input  logic [AW-1:0] resp_dst,
   output logic          access_out,
   output logic [PW-1:0] packet_out
);

   logic [GW-1:0] data_q;   // Register value at read time
   logic [AW-1:0] dst_q;    // Requester address

   always_ff @(posedge clk) begin
      if (reset) begin
         data_q <= '0;
         dst_q  <= '0;
      end else if (resp_load) begin
         data_q <= rd_data;
         dst_q  <= resp_dst;
      end
   end

   // Read response, always a word, no source address
   always_comb begin
      packet_out = '0;
      packet_out[WRITE_BIT]                = 1'b0;
      packet_out[DATAMODE_LSB +: DM_W]     = DM_WORD;
      packet_out[CTRLMODE_LSB +: CM_W]     = '0;
      packet_out[DSTADDR_LSB +: AW]        = dst_q;
      packet_out[DATA_LSB +: GW]           = data_q;
      packet_out[SRCADDR_LSB +: AW]        = '0;
   end

   assign access_out = resp_send;

endmodule

// ==== gpio_top.sv ====
module gpio_top
   import emesh_pkg::*, gpio_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          access_in,
   input  logic [PW-1:0] packet_in,
   output logic          wait_out,
   output logic          access_out,
   output logic [PW-1:0] packet_out,
   input  logic          credit_in,
   input  logic [GW-1:0] gpio_in,
   output logic [GW-1:0] gpio_out,
   output logic [GW-1:0] gpio_en,
   output logic          gpio_irq
);

   logic [GW-1:0] pins_sync;
   logic [GW-1:0] rise;
   logic [GW-1:0] rd_data;
   logic [GW-1:0] wr_data;
   logic          reg_wr;
   gpio_reg_e     reg_sel;
   logic          resp_load;
   logic          resp_send;   // Also spends a credit
   logic [AW-1:0] resp_dst;
   logic          has_credit;

   // ##############################
   // Pin side
   // ##############################
   gpio_input_sync u_sync (
      .clk       (clk),
      .reset     (reset),
      .pins      (gpio_in),
      .pins_sync (pins_sync),
      .rise      (rise)
   );

   gpio_regs u_regs (
      .clk       (clk),
      .reset     (reset),
      .reg_wr    (reg_wr),
      .reg_sel   (reg_sel),
      .wr_data   (wr_data),
      .pins_sync (pins_sync),
      .rise      (rise),
      .rd_data   (rd_data),
      .gpio_out  (gpio_out),
      .gpio_en   (gpio_en),
      .gpio_irq  (gpio_irq)
   );

   // ##############################
   // Mesh side
   // ##############################
   gpio_ctrl_fsm u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .has_credit (has_credit),
      .wait_out   (wait_out),
      .reg_wr     (reg_wr),
      .reg_sel    (reg_sel),
      .wr_data    (wr_data),
      .resp_load  (resp_load),
      .resp_send  (resp_send),
      .resp_dst   (resp_dst)
   );

   credit_counter u_credit (
      .clk        (clk),
      .reset      (reset),
      .credit_in  (credit_in),
      .consume    (resp_send),
      .has_credit (has_credit)
   );

   resp_packer u_resp (
      .clk        (clk),
      .reset      (reset),
      .resp_load  (resp_load),
      .resp_send  (resp_send),
      .rd_data    (rd_data),
      .resp_dst   (resp_dst),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// ==== gpio_checker.sv ====
module gpio_checker
   import emesh_pkg::*, gpio_pkg::*;
(
   input logic          clk,
   input logic          reset,
   input logic          access_in,
   input logic [PW-1:0] packet_in,
   input logic          wait_out,
   input logic          access_out,
   input logic [PW-1:0] packet_out,
   input logic          credit_in,
   input logic [GW-1:0] gpio_out,
   input logic [GW-1:0] gpio_en
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [CREDIT_W-1:0] credits;        // Credits seen from the ports
   logic                read_pending;   // Read taken, reply not yet out

   always_ff @(posedge clk) begin
      if (reset) begin
         credits      <= CREDIT_W'(RESP_CREDITS);
         read_pending <= 1'b0;
      end else begin
         if (credit_in && !access_out && credits != CREDIT_W'(RESP_CREDITS))
            credits <= credits + 1'b1;
         else if (access_out && !credit_in && credits != '0)
            credits <= credits - 1'b1;
         if (access_out)
            read_pending <= 1'b0;
         else if (access_in && !wait_out && !packet_in[WRITE_BIT])
            read_pending <= 1'b1;
      end
   end

   // ##############################
   // Response side
   // ##############################
   a_send_needs_credit : assert property (@(posedge clk) disable iff (reset)
      access_out |-> (credits != '0))
      else $error("access_out high with no credit left");

   a_send_one_cycle : assert property (@(posedge clk) disable iff (reset)
      access_out |=> !access_out)
      else $error("access_out held longer than one cycle");

   // ##############################
   // Request side
   // ##############################
   a_idle_no_wait : assert property (@(posedge clk) disable iff (reset)
      !read_pending |-> !wait_out)
      else $error("wait_out high with no read outstanding");

   // An accepted request shows up on the pins or the reply one edge later
   a_no_accept_busy : assert property (@(posedge clk) disable iff (reset)
      wait_out |=> ($stable(gpio_out) && $stable(gpio_en) && $stable(packet_out)))
      else $error("request accepted during wait_out");

endmodule

bind gpio_top gpio_checker chk (
   .clk        (clk),
   .reset      (reset),
   .access_in  (access_in),
   .packet_in  (packet_in),
   .wait_out   (wait_out),
   .access_out (access_out),
   .packet_out (packet_out),
   .credit_in  (credit_in),
   .gpio_out   (gpio_out),
   .gpio_en    (gpio_en)
);

// ==== tb_gpio.sv ====
module tb_gpio
   import emesh_pkg::*, gpio_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT  = 20;   // Cycles before a wait gives up
   localparam int HOLD_CYCLES = 6;    // Back-pressure window
   localparam int NUM_STEPS   = 11;

   typedef enum logic {OP_WR, OP_RD} op_e;

   typedef struct packed {
      op_e           op;
      gpio_reg_e     addr;
      logic [GW-1:0] data;
      logic [GW-1:0] exp;              // Read word, unused on writes
   } step_t;

   logic          clk;
   logic          reset;
   logic          access_in;
   logic [PW-1:0] packet_in;
   logic          wait_out;
   logic          access_out;
   logic [PW-1:0] packet_out;
   logic          credit_in;
   logic [GW-1:0] gpio_in;
   logic [GW-1:0] gpio_out;
   logic [GW-1:0] gpio_en;
   logic          gpio_irq;

   integer        seed = 32'h32f0_4e3a;
   logic [GW-1:0] m_dir = '0;          // Model of the direction register
   logic [GW-1:0] m_out = '0;          // Model of the output register
   logic [AW-1:0] src;

   // Register sequence, expected words worked out by hand
   step_t steps [NUM_STEPS] = '{
      '{OP_WR, REG_DIR,    32'h0000_ffff, 32'h0},
      '{OP_WR, REG_OUT,    32'ha5a5_1234, 32'h0},
      '{OP_RD, REG_DIR,    32'h0,         32'h0000_ffff},
      '{OP_RD, REG_OUT,    32'h0,         32'ha5a5_1234},
      '{OP_WR, REG_OUTSET, 32'h0000_00f0, 32'h0},   // -> a5a5_12f4
      '{OP_WR, REG_OUTCLR, 32'ha500_0000, 32'h0},   // -> 00a5_12f4
      '{OP_WR, REG_OUTXOR, 32'hffff_0000, 32'h0},   // -> ff5a_12f4
      '{OP_RD, REG_OUTSET, 32'h0,         32'hff5a_12f4},
      '{OP_WR, REG_IMASK,  32'h0000_000f, 32'h0},
      '{OP_RD, REG_IMASK,  32'h0,         32'h0000_000f},
      '{OP_RD, REG_OUT,    32'h0,         32'hff5a_12f4}
   };

   gpio_top uut (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .credit_in  (credit_in),
      .gpio_in    (gpio_in),
      .gpio_out   (gpio_out),
      .gpio_en    (gpio_en),
      .gpio_irq   (gpio_irq)
   );

   always #2 clk = ~clk;               // 4 ns period

   // ##############################
   // Reporting and compare tasks
   // ##############################
   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Done: errors found");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_word(input logic [GW-1:0] got, input logic [GW-1:0] exp,
                             input string what);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                             $time, what, got, exp));
   endtask

   task automatic check_addr(input logic [AW-1:0] got, input logic [AW-1:0] exp,
                             input string what);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                             $time, what, got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                             $time, what, got, exp));
   endtask

   task automatic check_mode(input datamode_e got, input datamode_e exp, input string what);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t ns: %s is %s, expected %s",
                             $time, what, got.name(), exp.name()));
   endtask

   // ##############################
   // Bus tasks
   // ##############################
   function automatic logic [PW-1:0] build_packet(input op_e op, input gpio_reg_e addr,
                                                  input logic [GW-1:0] data,
                                                  input logic [AW-1:0] from);
      logic [PW-1:0] pkt;
      pkt = '0;
      pkt[WRITE_BIT]             = (op == OP_WR);
      pkt[DATAMODE_LSB +: DM_W]  = DM_WORD;
      pkt[DSTADDR_LSB +: AW]     = {16'h8100, 11'h0, addr, 2'b00};   // Block base plus offset
      pkt[DATA_LSB +: GW]        = data;
      pkt[SRCADDR_LSB +: AW]     = from;
      return pkt;
   endfunction

   task automatic send_packet(input op_e op, input gpio_reg_e addr,
                              input logic [GW-1:0] data, input logic [AW-1:0] from);
      int n;
      n = 0;
      @(negedge clk);
      while (wait_out) begin          // Block busy with a read
         n++;
         if (n > WAIT_LIMIT)
            abort_run("Timed out waiting for wait_out to drop before a request");
         @(negedge clk);
      end
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= build_packet(op, addr, data, from);
      @(posedge clk);                 // Accepted on this edge
      access_in <= 1'b0;
   endtask

   task automatic await_response(input logic [GW-1:0] exp_data, input logic [AW-1:0] exp_dst);
      int n;
      n = 0;
      @(negedge clk);
      while (!access_out) begin
         n++;
         if (n > WAIT_LIMIT)
            abort_run("Timed out waiting for access_out on a read response");
         @(negedge clk);
      end
      check_bit(packet_out[WRITE_BIT], 1'b0, "response write flag");
      check_mode(datamode_e'(packet_out[DATAMODE_LSB +: DM_W]), DM_WORD, "response data mode");
      check_addr(packet_out[DSTADDR_LSB +: AW], exp_dst, "response dstaddr");
      check_addr(packet_out[SRCADDR_LSB +: AW], '0, "response srcaddr");
      check_word(packet_out[DATA_LSB +: GW], exp_data, "response data");
   endtask

   task automatic return_credit();
      @(posedge clk);
      credit_in <= 1'b1;              // One-cycle credit pulse
      @(posedge clk);
      credit_in <= 1'b0;
   endtask

   task automatic write_reg(input gpio_reg_e addr, input logic [GW-1:0] data);
      send_packet(OP_WR, addr, data, $random(seed));
      case (addr)
         REG_DIR:    m_dir = data;
         REG_OUT:    m_out = data;
         REG_OUTCLR: m_out = m_out & ~data;
         REG_OUTSET: m_out = m_out | data;
         REG_OUTXOR: m_out = m_out ^ data;
         default: ;                   // No pin-visible effect
      endcase
      @(negedge clk);
      check_word(gpio_out, m_out, "gpio_out after write");
      check_word(gpio_en, m_dir, "gpio_en after write");
   endtask

   task automatic read_reg(input gpio_reg_e addr, input logic [GW-1:0] exp, input logic give_back);
      logic [AW-1:0] from;
      from = $random(seed);
      send_packet(OP_RD, addr, '0, from);
      await_response(exp, from);
      if (give_back)
         return_credit();
   endtask

   // ##############################
   // Main sequence
   // ##############################
   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      credit_in = 1'b0;
      gpio_in   = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_bit(wait_out, 1'b0, "wait_out after reset");
      check_bit(access_out, 1'b0, "access_out after reset");
      check_bit(gpio_irq, 1'b0, "gpio_irq after reset");
      check_word(gpio_out, '0, "gpio_out after reset");
      check_word(gpio_en, '0, "gpio_en after reset");

      for (int i = 0; i < NUM_STEPS; i++) begin
         if (steps[i].op == OP_WR)
            write_reg(steps[i].addr, steps[i].data);
         else
            read_reg(steps[i].addr, steps[i].exp, 1'b1);
      end

      // Masked edge on bit 0
      @(posedge clk);
      gpio_in <= 32'h0000_0001;
      repeat (4) @(posedge clk);      // Sync plus latch
      @(negedge clk);
      check_bit(gpio_irq, 1'b0, "gpio_irq on masked edge");
      read_reg(REG_IN, 32'h0000_0001, 1'b1);
      read_reg(REG_ILAT, 32'h0000_0001, 1'b1);

      // Unmasked edge on bit 31
      @(posedge clk);
      gpio_in <= 32'h8000_0001;
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_bit(gpio_irq, 1'b1, "gpio_irq on unmasked edge");
      write_reg(REG_ILAT, 32'hffff_ffff);
      check_bit(gpio_irq, 1'b0, "gpio_irq after latch clear");
      read_reg(REG_ILAT, 32'h0, 1'b1);
      read_reg(REG_IN, 32'h8000_0001, 1'b1);

      // Credit starvation
      repeat (RESP_CREDITS) read_reg(REG_OUT, m_out, 1'b0);
      src = $random(seed);
      send_packet(OP_RD, REG_DIR, '0, src);
      access_in <= 1'b1;              // Write offered while the read is stuck
      packet_in <= build_packet(OP_WR, REG_DIR, ~m_dir, $random(seed));
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         check_bit(wait_out, 1'b1, "wait_out without credit");
         check_bit(access_out, 1'b0, "access_out without credit");
         check_word(gpio_en, m_dir, "gpio_en with write refused");
      end
      @(posedge clk);
      access_in <= 1'b0;              // Requester gives up
      return_credit();                // Releases the held read
      await_response(m_dir, src);
      return_credit();
      @(negedge clk);
      check_bit(wait_out, 1'b0, "wait_out after released read");

      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== sim.f ====
emesh_pkg.sv
gpio_pkg.sv
gpio_input_sync.sv
gpio_regs.sv
credit_counter.sv
gpio_ctrl_fsm.sv
resp_packer.sv
gpio_top.sv
gpio_checker.sv
tb_gpio.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module tb_gpio \
   -f sim.f

./obj_dir/Vtb_gpio
